/* run.sh */
#!/bin/sh
# Builds the feedback divider testbench with Verilator and runs it.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert \
  --top-module fbDividerTb \
  -f sim.f \
  -o fbDividerSim
status=$?
if [ "$status" -ne 0 ]; then
  echo "verilator build failed with status $status"
  exit 1
fi

output=$(./obj_dir/fbDividerSim 2>&1)
status=$?
printf '%s\n' "$output"

if [ "$status" -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if printf '%s\n' "$output" | grep -qx "sim passed"; then
  exit 0
fi

echo "pass message not found in simulation output"
exit 1

/* sim.f */
+incdir+src
src/fbDividerPkg.sv
src/majorityVoter.sv
src/tmrDownCounter.sv
src/tapGateBank.sv
src/feedbackDivider.sv
verification/fbDivider_asserts.sv
verification/fbDividerTb.sv

/* src/fbDividerPkg.sv */
// Feedback divider types
`include "fbDivider_cfg.svh"

package fbDividerPkg;

  // counter state and gated tap groups.
  // bit i repeats every 2^(i+1) cycles.
  typedef logic [`DIV_WIDTH-1:0] tapVec_t;

  // one enable in three copies.
  // bit 0 is copy A.
  typedef logic [`TMR_COPIES-1:0] tmrBit_t;

  // per-tap external-clock enables in three copies.
  // element 0 is copy A.
  typedef tapVec_t [`TMR_COPIES-1:0] tapEnableTmr_t;

endpackage

/* src/fbDivider_cfg.svh */
// Feedback divider configuration
`ifndef FBDIVIDER_CFG_SVH
`define FBDIVIDER_CFG_SVH

// counter bits, one divided-clock tap per bit.
// bit 0 is the 640M tap and bit 4 the 40M tap.
`define DIV_WIDTH 5

// redundant copies of the counter and of every enable.
// copy A sits at index 0, copy C at index 2.
`define TMR_COPIES 3

`endif

/* src/feedbackDivider.sv */
// PLL feedback divider top
`timescale 1ns/1ps

module feedbackDivider (
  input  logic                        clk1G28prebA,
  input  logic                        enableA,
  input  fbDividerPkg::tapEnableTmr_t eclkEnable,
  input  fbDividerPkg::tmrBit_t       serEnable,
  input  fbDividerPkg::tmrBit_t       desEnable,
  input  fbDividerPkg::tmrBit_t       psEnable,
  output fbDividerPkg::tapVec_t       eclkTaps,
  output fbDividerPkg::tapVec_t       serTaps,
  output fbDividerPkg::tapVec_t       desTaps,
  output fbDividerPkg::tapVec_t       psTaps,
  output logic                        pllFeedback,
  output logic                        desEnableVoted,
  output logic                        enableTmrError
);

  import fbDividerPkg::*;

  tapVec_t divTaps; // voted counter state.

  tmrDownCounter i_counter (
    .clk1G28prebA (clk1G28prebA),
    .enableA      (enableA),
    .divTaps      (divTaps)
  );

  // taps leave one cycle after the counter.
  tapGateBank i_gateBank (
    .clk1G28prebA   (clk1G28prebA),
    .enableA        (enableA),
    .divTaps        (divTaps),
    .eclkEnable     (eclkEnable),
    .serEnable      (serEnable),
    .desEnable      (desEnable),
    .psEnable       (psEnable),
    .eclkTaps       (eclkTaps),
    .serTaps        (serTaps),
    .desTaps        (desTaps),
    .psTaps         (psTaps),
    .pllFeedback    (pllFeedback),
    .desEnableVoted (desEnableVoted),
    .enableTmrError (enableTmrError)
  );

endmodule

/* src/majorityVoter.sv */
// Two-of-three majority voter
`timescale 1ns/1ps

module majorityVoter #(
  parameter int WIDTH = 1
) (
  input  logic [WIDTH-1:0] inA,
  input  logic [WIDTH-1:0] inB,
  input  logic [WIDTH-1:0] inC,
  output logic [WIDTH-1:0] voted,
  output logic             tmrErr
);

  logic [WIDTH-1:0] diffAB;
  logic [WIDTH-1:0] diffBC;

  // bitwise vote.
  assign voted = (inA & inB) | (inB & inC) | (inA & inC);

  assign diffAB = inA ^ inB;
  assign diffBC = inB ^ inC; // A and C differing implies one of these.

  assign tmrErr = |(diffAB | diffBC);

endmodule

/* src/tapGateBank.sv */
// Gated divider tap bank
`timescale 1ns/1ps
`include "fbDivider_cfg.svh"

module tapGateBank (
  input  logic                        clk1G28prebA,
  input  logic                        enableA,
  input  fbDividerPkg::tapVec_t       divTaps,
  input  fbDividerPkg::tapEnableTmr_t eclkEnable,
  input  fbDividerPkg::tmrBit_t       serEnable,
  input  fbDividerPkg::tmrBit_t       desEnable,
  input  fbDividerPkg::tmrBit_t       psEnable,
  output fbDividerPkg::tapVec_t       eclkTaps,
  output fbDividerPkg::tapVec_t       serTaps,
  output fbDividerPkg::tapVec_t       desTaps,
  output fbDividerPkg::tapVec_t       psTaps,
  output logic                        pllFeedback,
  output logic                        desEnableVoted,
  output logic                        enableTmrError
);

  import fbDividerPkg::*;

  tapVec_t eclkVoted;
  logic    serVoted;
  logic    desVoted;
  logic    psVoted;
  logic    eclkErr;
  logic    serErr;
  logic    desErr;
  logic    psErr;
  tapVec_t eclkGated;
  tapVec_t serGated;
  tapVec_t desGated;
  tapVec_t psGated;

  majorityVoter #(.WIDTH(`DIV_WIDTH)) eclkVoter (
    .inA    (eclkEnable[0]),
    .inB    (eclkEnable[1]),
    .inC    (eclkEnable[2]),
    .voted  (eclkVoted),
    .tmrErr (eclkErr)
  );

  majorityVoter #(.WIDTH(1)) serVoter (
    .inA    (serEnable[0]),
    .inB    (serEnable[1]),
    .inC    (serEnable[2]),
    .voted  (serVoted),
    .tmrErr (serErr)
  );

  majorityVoter #(.WIDTH(1)) desVoter (
    .inA    (desEnable[0]),
    .inB    (desEnable[1]),
    .inC    (desEnable[2]),
    .voted  (desVoted),
    .tmrErr (desErr)
  );

  majorityVoter #(.WIDTH(1)) psVoter (
    .inA    (psEnable[0]),
    .inB    (psEnable[1]),
    .inC    (psEnable[2]),
    .voted  (psVoted),
    .tmrErr (psErr)
  );

  assign eclkGated = divTaps & eclkVoted; // separate enable per tap.
  assign serGated  = divTaps & {`DIV_WIDTH{serVoted}};
  assign desGated  = divTaps & {`DIV_WIDTH{desVoted}};
  assign psGated   = divTaps & {`DIV_WIDTH{psVoted}};

  // single retiming stage for every output.
  always_ff @(posedge clk1G28prebA or negedge enableA)
  begin
    if (!enableA)
    begin
      eclkTaps       <= '0;
      serTaps        <= '0;
      desTaps        <= '0;
      psTaps         <= '0;
      pllFeedback    <= 1'b0;
      desEnableVoted <= 1'b0;
      enableTmrError <= 1'b0;
    end
    else
    begin
      eclkTaps       <= eclkGated;
      serTaps        <= serGated;
      desTaps        <= desGated;
      psTaps         <= psGated;
      pllFeedback    <= divTaps[`DIV_WIDTH-1]; // ungated 40M tap.
      desEnableVoted <= desVoted;
      enableTmrError <= eclkErr | serErr | desErr | psErr;
    end
  end

endmodule

/* src/tmrDownCounter.sv */
// Triplicated feedback down-counter
`timescale 1ns/1ps
`include "fbDivider_cfg.svh"

module tmrDownCounter (
  input  logic                  clk1G28prebA,
  input  logic                  enableA,
  output fbDividerPkg::tapVec_t divTaps
);

  import fbDividerPkg::*;

  tapVec_t cntA;
  tapVec_t cntB;
  tapVec_t cntC;
  tapVec_t decA;
  tapVec_t decB;
  tapVec_t decC;
  tapVec_t nextA;
  tapVec_t nextB;
  tapVec_t nextC;

  assign decA = cntA - tapVec_t'(1); // wraps from 0 to 31.
  assign decB = cntB - tapVec_t'(1);
  assign decC = cntC - tapVec_t'(1);

  // one voter per copy so a fault in a voter reaches one copy only.
  majorityVoter #(.WIDTH(`DIV_WIDTH)) nextVoterA (
    .inA    (decA),
    .inB    (decB),
    .inC    (decC),
    .voted  (nextA),
    .tmrErr ()
  );

  majorityVoter #(.WIDTH(`DIV_WIDTH)) nextVoterB (
    .inA    (decA),
    .inB    (decB),
    .inC    (decC),
    .voted  (nextB),
    .tmrErr ()
  );

  majorityVoter #(.WIDTH(`DIV_WIDTH)) nextVoterC (
    .inA    (decA),
    .inB    (decB),
    .inC    (decC),
    .voted  (nextC),
    .tmrErr ()
  );

  always_ff @(posedge clk1G28prebA or negedge enableA)
  begin
    if (!enableA)
    begin
      cntA <= '0;
      cntB <= '0;
      cntC <= '0;
    end
    else
    begin
      cntA <= nextA; // a corrupted copy is outvoted here.
      cntB <= nextB;
      cntC <= nextC;
    end
  end

  // taps are the vote of the present copies.
  assign divTaps = (cntA & cntB) | (cntB & cntC) | (cntA & cntC);

endmodule

/* verification/fbDividerTb.sv */
// Feedback divider testbench
`timescale 1ns/1ps
`include "fbDivider_cfg.svh"

module fbDividerTb;

  import fbDividerPkg::*;

  localparam int countMod = 1 << `DIV_WIDTH;
  localparam int resetCycles = 5;
  localparam int watchMargin = 50;

  logic          clk1G28prebA;
  logic          enableA;
  tapEnableTmr_t eclkEnable;
  tmrBit_t       serEnable;
  tmrBit_t       desEnable;
  tmrBit_t       psEnable;
  tapVec_t       eclkTaps;
  tapVec_t       serTaps;
  tapVec_t       desTaps;
  tapVec_t       psTaps;
  logic          pllFeedback;
  logic          desEnableVoted;
  logic          enableTmrError;

  // tests as read from the data file.
  string         testName[$];
  tapEnableTmr_t eclkCopies[$];
  tmrBit_t       serCopies[$];
  tmrBit_t       desCopies[$];
  tmrBit_t       psCopies[$];
  int            faultSel[$];
  int            cycleCount[$];

  // enables seen by the DUT at the next rising edge.
  tapEnableTmr_t appliedEclk;
  tmrBit_t       appliedSer;
  tmrBit_t       appliedDes;
  tmrBit_t       appliedPs;

  string currentTest;
  int    edgeCount;
  int    totalCycles;
  bit    testsLoaded;

  feedbackDivider i_dut (
    .clk1G28prebA   (clk1G28prebA),
    .enableA        (enableA),
    .eclkEnable     (eclkEnable),
    .serEnable      (serEnable),
    .desEnable      (desEnable),
    .psEnable       (psEnable),
    .eclkTaps       (eclkTaps),
    .serTaps        (serTaps),
    .desTaps        (desTaps),
    .psTaps         (psTaps),
    .pllFeedback    (pllFeedback),
    .desEnableVoted (desEnableVoted),
    .enableTmrError (enableTmrError)
  );

  initial
  begin
    clk1G28prebA = 1'b0;
    forever #2 clk1G28prebA = ~clk1G28prebA; // 4 ns period.
  end

  // per bit, a value held by at least two copies wins.
  function automatic tapVec_t voteBits(input tapVec_t a, input tapVec_t b, input tapVec_t c);
    tapVec_t result;
    int      ones;
    for (int i = 0; i < `DIV_WIDTH; i++)
    begin
      ones = int'(a[i]) + int'(b[i]) + int'(c[i]);
      result[i] = (ones >= 2);
    end
    return result;
  endfunction

  function automatic logic voteCopy(input tmrBit_t copies);
    return ($countones(copies) >= 2);
  endfunction

  function automatic logic copiesDiffer(input tmrBit_t copies);
    return (copies != '0) && (copies != '1);
  endfunction

  task automatic checkValue(input string signal, input logic [31:0] expected,
                            input logic [31:0] actual);
    if (expected !== actual)
    begin
      $display("Mismatch test=%s signal=%s edge=%0d expected=%0h actual=%0h",
               currentTest, signal, edgeCount, expected, actual);
      $display("sim failed");
      $fatal(1, "output check failed");
    end
  endtask

  task automatic loadTests();
    int            fd;
    int            fields;
    string         line;
    string         name;
    tapVec_t       eA;
    tapVec_t       eB;
    tapVec_t       eC;
    tmrBit_t       s;
    tmrBit_t       d;
    tmrBit_t       p;
    int            fault;
    int            cycles;
    tapEnableTmr_t e;
    fd = $fopen("verification/fbDivider_input.txt", "r");
    if (fd == 0)
    begin
      $display("cannot open the stimulus file verification/fbDivider_input.txt");
      $display("sim failed");
      $fatal(1, "no stimulus");
    end
    totalCycles = 0;
    while ($fgets(line, fd) > 0)
    begin
      if (line.len() < 2 || line[0] == "#")
        continue; // comment or blank line.
      fields = $sscanf(line, "%s %h %h %h %b %b %b %d %d",
                       name, eA, eB, eC, s, d, p, fault, cycles);
      if (fields != 9)
      begin
        $display("malformed stimulus line: %s", line);
        $display("sim failed");
        $fatal(1, "bad stimulus");
      end
      e[0] = eA;
      e[1] = eB;
      e[2] = eC;
      testName.push_back(name);
      eclkCopies.push_back(e);
      serCopies.push_back(s);
      desCopies.push_back(d);
      psCopies.push_back(p);
      faultSel.push_back(fault);
      cycleCount.push_back(cycles);
      totalCycles += cycles;
    end
    $fclose(fd);
  endtask

  // drives one test's copies, flipping a random copy where asked.
  task automatic applyTest(input int t);
    int            copy;
    tapEnableTmr_t e;
    tmrBit_t       s;
    tmrBit_t       d;
    tmrBit_t       p;
    e = eclkCopies[t];
    s = serCopies[t];
    d = desCopies[t];
    p = psCopies[t];
    currentTest = testName[t];
    if (faultSel[t] != 0)
    begin
      copy = int'($urandom % `TMR_COPIES);
      case (faultSel[t])
        1: e[copy] = ~e[copy];
        2: s[copy] = ~s[copy];
        3: d[copy] = ~d[copy];
        default: p[copy] = ~p[copy];
      endcase
    end
    eclkEnable  = e;
    serEnable   = s;
    desEnable   = d;
    psEnable    = p;
    appliedEclk = e;
    appliedSer  = s;
    appliedDes  = d;
    appliedPs   = p;
  endtask

  task automatic checkOutputs();
    tapVec_t cnt;
    tapVec_t eclkExp;
    tapVec_t serExp;
    tapVec_t desExp;
    tapVec_t psExp;
    logic    pllExp;
    logic    desVotedExp;
    logic    errExp;
    eclkExp     = '0;
    serExp      = '0;
    desExp      = '0;
    psExp       = '0;
    pllExp      = 1'b0;
    desVotedExp = 1'b0;
    errExp      = 1'b0;
    if (edgeCount > 0)
    begin
      // counter value held just before the last edge.
      cnt = tapVec_t'((countMod - ((edgeCount - 1) % countMod)) % countMod);
      eclkExp     = cnt & voteBits(appliedEclk[0], appliedEclk[1], appliedEclk[2]);
      serExp      = voteCopy(appliedSer) ? cnt : '0;
      desExp      = voteCopy(appliedDes) ? cnt : '0;
      psExp       = voteCopy(appliedPs) ? cnt : '0;
      pllExp      = cnt[`DIV_WIDTH-1];
      desVotedExp = voteCopy(appliedDes);
      errExp      = (appliedEclk[0] != appliedEclk[1]) || (appliedEclk[1] != appliedEclk[2])
                    || copiesDiffer(appliedSer) || copiesDiffer(appliedDes)
                    || copiesDiffer(appliedPs);
    end
    checkValue("eclkTaps", 32'(eclkExp), 32'(eclkTaps));
    checkValue("serTaps", 32'(serExp), 32'(serTaps));
    checkValue("desTaps", 32'(desExp), 32'(desTaps));
    checkValue("psTaps", 32'(psExp), 32'(psTaps));
    checkValue("pllFeedback", 32'(pllExp), 32'(pllFeedback));
    checkValue("desEnableVoted", 32'(desVotedExp), 32'(desEnableVoted));
    checkValue("enableTmrError", 32'(errExp), 32'(enableTmrError));
  endtask

  task automatic runCycles(input int n);
    for (int c = 0; c < n; c++)
    begin
      @(posedge clk1G28prebA);
      edgeCount++;
      @(negedge clk1G28prebA);
      checkOutputs(); // outputs are stable half a cycle after the edge.
    end
  endtask

  initial
  begin
    wait (testsLoaded);
    #((totalCycles + resetCycles + watchMargin) * 4);
    $display("simulation timed out");
    $display("sim failed");
    $fatal(1, "watchdog expired");
  end

  initial
  begin
    enableA     = 1'b0;
    eclkEnable  = '1; // live enables with a split serializer copy while reset holds.
    serEnable   = 3'b011;
    desEnable   = '1;
    psEnable    = '1;
    appliedEclk = '0;
    appliedSer  = '0;
    appliedDes  = '0;
    appliedPs   = '0;
    edgeCount   = 0;
    currentTest = "reset";
    void'($urandom(32'hf020));
    loadTests();
    testsLoaded = 1'b1;
    repeat (resetCycles)
    begin
      @(negedge clk1G28prebA);
      checkOutputs();
    end
    enableA = 1'b1; // released on a falling edge.
    for (int t = 0; t < testName.size(); t++)
    begin
      applyTest(t);
      runCycles(cycleCount[t]);
    end
    $display("sim passed");
    $finish;
  end

endmodule

/* verification/fbDivider_asserts.sv */
// Feedback divider assertions
`timescale 1ns/1ps
`include "fbDivider_cfg.svh"

module fbDividerAsserts (
  input logic                        clk1G28prebA,
  input logic                        enableA,
  input fbDividerPkg::tapEnableTmr_t eclkEnable,
  input fbDividerPkg::tmrBit_t       serEnable,
  input fbDividerPkg::tmrBit_t       desEnable,
  input fbDividerPkg::tmrBit_t       psEnable,
  input fbDividerPkg::tapVec_t       eclkTaps,
  input fbDividerPkg::tapVec_t       serTaps,
  input fbDividerPkg::tapVec_t       desTaps,
  input fbDividerPkg::tapVec_t       psTaps,
  input logic                        pllFeedback,
  input logic                        desEnableVoted,
  input logic                        enableTmrError
);

  logic serVote;
  logic copiesAgree;
  logic outputsClear;

  assign serVote = ($countones(serEnable) >= 2);

  assign copiesAgree = (eclkEnable[0] == eclkEnable[1]) && (eclkEnable[1] == eclkEnable[2])
                       && ((serEnable == '0) || (serEnable == '1))
                       && ((desEnable == '0) || (desEnable == '1))
                       && ((psEnable == '0) || (psEnable == '1));

  assign outputsClear = (eclkTaps == '0) && (serTaps == '0) && (desTaps == '0)
                        && (psTaps == '0) && !pllFeedback && !desEnableVoted
                        && !enableTmrError;

  resetClear: assert property (@(posedge clk1G28prebA) !enableA |-> outputsClear)
    else $error("outputs not cleared while reset is active");

  // the 40M tap toggles only as the four lower taps wrap from 0 to all ones.
  pllOnWrap: assert property (@(posedge clk1G28prebA) disable iff (!enableA)
      ($changed(pllFeedback) && $past(serVote, 1) && $past(serVote, 2))
      |-> (($past(serTaps[`DIV_WIDTH-2:0]) == '0) && (serTaps[`DIV_WIDTH-2:0] == '1)))
    else $error("pllFeedback changed without a wrap of the lower serializer taps");

  noFalseError: assert property (@(posedge clk1G28prebA) disable iff (!enableA)
      $past(copiesAgree) |-> !enableTmrError)
    else $error("enableTmrError raised although all enable copies agree");

endmodule

bind feedbackDivider fbDividerAsserts i_asserts (
  .clk1G28prebA   (clk1G28prebA),
  .enableA        (enableA),
  .eclkEnable     (eclkEnable),
  .serEnable      (serEnable),
  .desEnable      (desEnable),
  .psEnable       (psEnable),
  .eclkTaps       (eclkTaps),
  .serTaps        (serTaps),
  .desTaps        (desTaps),
  .psTaps         (psTaps),
  .pllFeedback    (pllFeedback),
  .desEnableVoted (desEnableVoted),
  .enableTmrError (enableTmrError)
);

/* verification/fbDivider_input.txt */
# name eclkA eclkB eclkC ser des ps fault cycles
# eclk copies in hex; ser, des and ps copies in binary as C B A
# fault picks a random copy to flip: 0 none, 1 eclk, 2 ser, 3 des, 4 ps
allOn 1f 1f 1f 111 111 111 0 64
eclkAlt 15 15 15 111 111 111 0 32
eclkAltInv 0a 0a 0a 111 111 111 0 32
eclkLow 03 03 03 111 111 111 0 16
eclkHigh 18 18 18 111 111 111 0 16
eclkNone 00 00 00 111 111 111 0 8
eclkVoteSplit 15 1f 05 111 111 111 0 8
faultEclk 1f 1f 1f 111 111 111 1 8
faultSer 1f 1f 1f 111 111 111 2 8
faultDes 1f 1f 1f 111 111 111 3 8
faultPs 1f 1f 1f 111 111 111 4 8
serSplit 1f 1f 1f 011 111 111 0 6
desSplitOff 1f 1f 1f 111 100 111 0 6
recover 1f 1f 1f 111 111 111 0 4
serOff 1f 1f 1f 000 111 111 0 16
serOn 1f 1f 1f 111 111 111 0 4
desOff 1f 1f 1f 111 000 111 0 16
desOn 1f 1f 1f 111 111 111 0 4
psOff 1f 1f 1f 111 111 000 0 16
psOn 1f 1f 1f 111 111 111 0 4
allOff 00 00 00 000 000 000 0 8
faultAllOff 00 00 00 000 000 000 2 6
faultPsOff 00 00 00 000 000 000 4 6
finalOn 1f 1f 1f 111 111 111 0 40
